// ==== include/axi_consts.svh ====
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// AXI burst type encodings
`define BURST_FIXED 2'b00
`define BURST_INCR  2'b01
`define BURST_WRAP  2'b10

// the size field holds log2 of the bytes in one beat
`define SIZE_4B 3'b010

`endif

// ==== source/dma_pkg.sv ====
`include "axi_consts.svh"

package dma_pkg;

  localparam int DMEM_AWIDTH = 10;  // 1024 words of DMem
  localparam int AXI_AWIDTH  = 32;
  localparam int AXI_DWIDTH  = 32;

  typedef logic [AXI_AWIDTH-1:0]   axi_addr_t;  // word address on the DDR side
  typedef logic [AXI_DWIDTH-1:0]   axi_data_t;
  typedef logic [DMEM_AWIDTH-1:0]  dmem_addr_t;
  typedef logic [AXI_DWIDTH/8-1:0] dmem_wbe_t;
  typedef logic [31:0]             xfer_len_t;  // length in words
  typedef logic [2:0]              axi_size_t;
  typedef logic [1:0]              axi_burst_t;

  // every request is a full-width incrementing burst
  localparam axi_burst_t BURST_INCR = `BURST_INCR;
  localparam axi_size_t  SIZE_4B    = `SIZE_4B;

  typedef enum logic [2:0] {
    IDLE,
    READ_REQ,
    READ_DATA,
    WRITE_REQ,
    WRITE_DATA,
    DONE
  } ctrl_state_t;

endpackage

// ==== source/dma_if.sv ====
`timescale 1ns/1ps

// latched transfer command with one writer and several readers
interface cmd_if;
  dma_pkg::axi_addr_t src_addr;
  dma_pkg::axi_addr_t dst_addr;
  dma_pkg::xfer_len_t len;
  dma_pkg::xfer_len_t burst_len;  // AXI length field that holds len minus one
  logic               dir;        // 1 moves DMem to DDR, 0 moves DDR to DMem

  modport latch (
    output src_addr,
    output dst_addr,
    output len,
    output burst_len,
    output dir
  );

  modport user (
    input src_addr,
    input dst_addr,
    input len,
    input burst_len,
    input dir
  );
endinterface

// single port of the synchronous data memory
interface dmem_if;
  dma_pkg::dmem_addr_t addr;
  dma_pkg::axi_data_t  din;
  dma_pkg::dmem_wbe_t  wbe;
  logic                en;
  dma_pkg::axi_data_t  dout;

  modport port (
    output addr,
    output din,
    output wbe,
    output en,
    input  dout
  );

  modport mem (
    input  addr,
    input  din,
    input  wbe,
    input  en,
    output dout
  );
endinterface

// ==== source/dma_cmd_latch.sv ====
`timescale 1ns/1ps

module dma_cmd_latch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  dma_pkg::axi_addr_t src_addr,
  input  dma_pkg::axi_addr_t dst_addr,
  input  dma_pkg::xfer_len_t len,
  input  logic               dir,
  input  logic               capture,
  cmd_if.latch               cmd
);

  logic load;

  assign load = capture & start;  // a command is taken only on a start seen in IDLE

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd.src_addr  <= '0;
      cmd.dst_addr  <= '0;
      cmd.len       <= '0;
      cmd.burst_len <= '0;
      cmd.dir       <= 1'b0;
    end else if (load) begin
      cmd.src_addr  <= src_addr;
      cmd.dst_addr  <= dst_addr;
      cmd.len       <= len;
      cmd.burst_len <= len - 1'b1;  // registered so the request fields come straight from flops
      cmd.dir       <= dir;
    end
  end

endmodule

// ==== source/dma_xfer_counter.sv ====
`timescale 1ns/1ps

module dma_xfer_counter (
  input  logic               clk,
  input  logic               rst_n,
  cmd_if.user                cmd,
  input  logic               clear,
  input  logic               read_beat,
  input  logic               fetch,
  input  dma_pkg::axi_data_t read_data,
  output logic               last_beat,
  dmem_if.port               mem
);

  dma_pkg::xfer_len_t offset;     // next DMem word relative to the base
  dma_pkg::xfer_len_t beat_cnt;   // data beats already moved
  dma_pkg::xfer_len_t beat_next;
  dma_pkg::axi_addr_t base;
  dma_pkg::axi_addr_t word_addr;
  logic               data_beat;

  // on the write path the first fetch is the prefetch at the request and carries no data
  assign data_beat = read_beat | (fetch & (offset != '0));
  assign beat_next = beat_cnt + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset   <= '0;
      beat_cnt <= '0;
    end else if (clear) begin
      offset   <= '0;
      beat_cnt <= '0;
    end else begin
      if (read_beat | fetch) begin
        offset <= offset + 1'b1;
      end
      if (data_beat) begin
        beat_cnt <= beat_next;
      end
    end
  end

  // the beat that fires now is the last one
  assign last_beat = (beat_next == cmd.len);

  // DMem is the destination when reading from DDR and the source when writing to it
  assign base      = cmd.dir ? cmd.src_addr : cmd.dst_addr;
  assign word_addr = base + offset;

  assign mem.addr = dma_pkg::dmem_addr_t'(word_addr);
  assign mem.din  = read_data;
  assign mem.wbe  = {$bits(dma_pkg::dmem_wbe_t){read_beat}};  // whole words only
  assign mem.en   = read_beat | fetch;

endmodule

// ==== source/dmem_ram.sv ====
`timescale 1ns/1ps

module dmem_ram (
  input logic clk,
  dmem_if.mem mem
);

  dma_pkg::axi_data_t ram [2**dma_pkg::DMEM_AWIDTH];

  // byte lanes are written independently
  always_ff @(posedge clk) begin
    if (mem.en) begin
      for (int b = 0; b < $bits(dma_pkg::dmem_wbe_t); b++) begin
        if (mem.wbe[b]) begin
          ram[mem.addr][8*b +: 8] <= mem.din[8*b +: 8];
        end
      end
    end
  end

  // dout keeps the last word read while en is low or a write is in progress
  always_ff @(posedge clk) begin
    if (mem.en && (mem.wbe == '0)) begin
      mem.dout <= ram[mem.addr];
    end
  end

endmodule

// ==== source/dma_ctrl.sv ====
`timescale 1ns/1ps

module dma_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  cmd_if.user  cmd,

  output logic capture,
  output logic clear,
  output logic read_beat,
  output logic fetch,
  input  logic last_beat,

  output logic rd_req_valid,
  input  logic rd_req_ready,
  input  logic rd_data_valid,
  output logic rd_data_ready,

  output logic wr_req_valid,
  input  logic wr_req_ready,
  output logic wr_data_valid,
  input  logic wr_data_ready,

  output logic done,
  output logic idle
);

  dma_pkg::ctrl_state_t state_q;
  dma_pkg::ctrl_state_t state_d;
  dma_pkg::ctrl_state_t state;
  logic                 done_q;
  logic                 rd_req_fire;
  logic                 rd_data_fire;
  logic                 wr_req_fire;
  logic                 wr_data_fire;

  // dir is latched on the same edge as the start, so both directions leave IDLE through
  // READ_REQ and the latched dir then turns it into a write request
  always_comb begin
    state = state_q;
    if ((state_q == dma_pkg::READ_REQ) && cmd.dir) begin
      state = dma_pkg::WRITE_REQ;
    end
  end

  assign rd_req_fire  = rd_req_valid & rd_req_ready;
  assign rd_data_fire = rd_data_valid & rd_data_ready;
  assign wr_req_fire  = wr_req_valid & wr_req_ready;
  assign wr_data_fire = wr_data_valid & wr_data_ready;

  always_comb begin
    state_d = state;
    case (state)
      dma_pkg::IDLE:       if (start) state_d = dma_pkg::READ_REQ;
      dma_pkg::READ_REQ:   if (rd_req_fire) state_d = dma_pkg::READ_DATA;
      dma_pkg::READ_DATA:  if (rd_data_fire && last_beat) state_d = dma_pkg::DONE;
      dma_pkg::WRITE_REQ:  if (wr_req_fire) state_d = dma_pkg::WRITE_DATA;
      dma_pkg::WRITE_DATA: if (wr_data_fire && last_beat) state_d = dma_pkg::DONE;
      dma_pkg::DONE:       state_d = dma_pkg::IDLE;
      default:             state_d = dma_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dma_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // done rises together with idle and is dropped by the next start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (state == dma_pkg::DONE) begin
      done_q <= 1'b1;
    end else if (start) begin
      done_q <= 1'b0;
    end
  end

  assign rd_req_valid  = (state == dma_pkg::READ_REQ);
  assign rd_data_ready = (state == dma_pkg::READ_DATA);
  assign wr_req_valid  = (state == dma_pkg::WRITE_REQ);
  assign wr_data_valid = (state == dma_pkg::WRITE_DATA);

  assign capture   = (state == dma_pkg::IDLE) & start;
  assign clear     = (state == dma_pkg::IDLE);  // counters sit at zero between transfers
  assign read_beat = rd_data_fire;              // each read beat goes straight into DMem
  assign fetch     = wr_req_fire | wr_data_fire; // prefetch word 0, then one word per beat

  assign done = done_q;
  assign idle = (state == dma_pkg::IDLE);

endmodule

// ==== source/dma_top.sv ====
`timescale 1ns/1ps

module dma_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 start,
  input  logic                 dir,
  input  dma_pkg::axi_addr_t   src_addr,
  input  dma_pkg::axi_addr_t   dst_addr,
  input  dma_pkg::xfer_len_t   len,
  output logic                 done,
  output logic                 idle,

  output logic                 rd_req_valid,
  input  logic                 rd_req_ready,
  output dma_pkg::axi_addr_t   rd_req_addr,
  output dma_pkg::xfer_len_t   rd_req_len,
  output dma_pkg::axi_size_t   rd_req_size,
  output dma_pkg::axi_burst_t  rd_req_burst,

  input  dma_pkg::axi_data_t   rd_data,
  input  logic                 rd_data_valid,
  output logic                 rd_data_ready,

  output logic                 wr_req_valid,
  input  logic                 wr_req_ready,
  output dma_pkg::axi_addr_t   wr_req_addr,
  output dma_pkg::xfer_len_t   wr_req_len,
  output dma_pkg::axi_size_t   wr_req_size,
  output dma_pkg::axi_burst_t  wr_req_burst,

  output dma_pkg::axi_data_t   wr_data,
  output logic                 wr_data_valid,
  input  logic                 wr_data_ready
);

  logic capture;
  logic clear;
  logic read_beat;
  logic fetch;
  logic last_beat;

  cmd_if  i_cmd ();
  dmem_if i_dmem ();

  dma_cmd_latch i_latch (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .src_addr (src_addr),
    .dst_addr (dst_addr),
    .len      (len),
    .dir      (dir),
    .capture  (capture),
    .cmd      (i_cmd.latch)
  );

  dma_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .cmd           (i_cmd.user),
    .capture       (capture),
    .clear         (clear),
    .read_beat     (read_beat),
    .fetch         (fetch),
    .last_beat     (last_beat),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .done          (done),
    .idle          (idle)
  );

  dma_xfer_counter i_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (i_cmd.user),
    .clear     (clear),
    .read_beat (read_beat),
    .fetch     (fetch),
    .read_data (rd_data),
    .last_beat (last_beat),
    .mem       (i_dmem.port)
  );

  dmem_ram i_ram (
    .clk (clk),
    .mem (i_dmem.mem)
  );

  // request fields come from the latched command, so they hold while valid is up
  assign rd_req_addr  = i_cmd.src_addr;
  assign rd_req_len   = i_cmd.burst_len;
  assign rd_req_size  = dma_pkg::SIZE_4B;
  assign rd_req_burst = dma_pkg::BURST_INCR;

  assign wr_req_addr  = i_cmd.dst_addr;
  assign wr_req_len   = i_cmd.burst_len;
  assign wr_req_size  = dma_pkg::SIZE_4B;
  assign wr_req_burst = dma_pkg::BURST_INCR;

  assign wr_data = i_dmem.dout;  // held by the RAM while the beat waits for ready

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== bench/tb_ddr_model.sv ====
`timescale 1ns/1ps

module tb_ddr_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall_en,
  input  logic        rd_req_valid,
  output logic        rd_req_ready,
  input  logic [31:0] rd_req_addr,
  input  logic [31:0] rd_req_len,
  input  logic [2:0]  rd_req_size,
  input  logic [1:0]  rd_req_burst,
  output logic [31:0] rd_data,
  output logic        rd_data_valid,
  input  logic        rd_data_ready,
  input  logic        wr_req_valid,
  output logic        wr_req_ready,
  input  logic [31:0] wr_req_addr,
  input  logic [31:0] wr_req_len,
  input  logic [2:0]  wr_req_size,
  input  logic [1:0]  wr_req_burst,
  input  logic [31:0] wr_data,
  input  logic        wr_data_valid,
  output logic        wr_data_ready
);

  logic [31:0] mem [0:4095];  // word addressed by the low 12 bits of the address
  logic [31:0] lfsr = 32'h3182;
  logic [31:0] rd_ptr;
  logic [31:0] rd_left;
  logic [31:0] wr_ptr;
  // the last request of either kind and a running count of requests
  logic [31:0] log_addr;
  logic [31:0] log_len;
  logic [2:0]  log_size;
  logic [1:0]  log_burst;
  int          req_count = 0;
  int          wr_beats = 0;

  // galois LFSR stepped once for each bit taken
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) w[i] = next_bit();
    return w;
  endfunction

  function automatic logic pick_ready();
    return stall_en ? next_bit() : 1'b1;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_req_ready  <= 1'b0;
      wr_req_ready  <= 1'b0;
      wr_data_ready <= 1'b0;
      rd_data_valid <= 1'b0;
      rd_data       <= '0;
      rd_ptr        <= '0;
      rd_left       <= '0;
      wr_ptr        <= '0;
    end else begin
      rd_req_ready  <= pick_ready();
      wr_req_ready  <= pick_ready();
      wr_data_ready <= pick_ready();
      if (rd_req_valid && rd_req_ready) begin
        log_addr  <= rd_req_addr;
        log_len   <= rd_req_len;
        log_size  <= rd_req_size;
        log_burst <= rd_req_burst;
        req_count <= req_count + 1;
        rd_ptr    <= rd_req_addr;
        rd_left   <= rd_req_len + 1;
      end
      if (rd_data_valid && rd_data_ready) begin
        rd_ptr        <= rd_ptr + 1;
        rd_left       <= rd_left - 1;
        rd_data_valid <= 1'b0;
      end else if (!rd_data_valid && rd_left != 0 && pick_ready()) begin
        rd_data       <= mem[rd_ptr[11:0]];  // held until the beat fires
        rd_data_valid <= 1'b1;
      end
      if (wr_req_valid && wr_req_ready) begin
        log_addr  <= wr_req_addr;
        log_len   <= wr_req_len;
        log_size  <= wr_req_size;
        log_burst <= wr_req_burst;
        req_count <= req_count + 1;
        wr_ptr    <= wr_req_addr;
      end
      if (wr_data_valid && wr_data_ready) begin
        mem[wr_ptr[11:0]] <= wr_data;
        wr_ptr            <= wr_ptr + 1;
        wr_beats          <= wr_beats + 1;
      end
    end
  end

endmodule

// ==== bench/dma_sva.sv ====
`timescale 1ns/1ps

module dma_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        rd_req_valid,
  input logic        rd_req_ready,
  input logic        rd_data_ready,
  input logic        wr_req_valid,
  input logic        wr_req_ready,
  input logic        wr_data_valid,
  input logic        wr_data_ready,
  input logic        done,
  input logic        idle,
  input logic [31:0] src_addr,
  input logic [31:0] dst_addr,
  input logic [31:0] burst_len
);

  logic busy;

  assign busy = rd_req_valid | rd_data_ready | wr_req_valid | wr_data_valid;

  valid_held : assert property (@(posedge clk) disable iff (!rst_n)
    ((rd_req_valid && !rd_req_ready) |=> rd_req_valid) and
    ((wr_req_valid && !wr_req_ready) |=> wr_req_valid) and
    ((wr_data_valid && !wr_data_ready) |=> wr_data_valid))
    else $error("a valid dropped before its handshake");

  flags_quiet : assert property (@(posedge clk) disable iff (!rst_n) busy |-> !idle && !done)
    else $error("idle or done high during a transfer");

  req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    ((rd_req_valid && !rd_req_ready) || (wr_req_valid && !wr_req_ready)) |=>
    ($stable(src_addr) && $stable(dst_addr) && $stable(burst_len)))
    else $error("request fields changed while valid was high");

endmodule

bind dma_ctrl dma_sva i_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .rd_req_valid  (rd_req_valid),
  .rd_req_ready  (rd_req_ready),
  .rd_data_ready (rd_data_ready),
  .wr_req_valid  (wr_req_valid),
  .wr_req_ready  (wr_req_ready),
  .wr_data_valid (wr_data_valid),
  .wr_data_ready (wr_data_ready),
  .done          (done),
  .idle          (idle),
  .src_addr      (cmd.src_addr),
  .dst_addr      (cmd.dst_addr),
  .burst_len     (cmd.burst_len)
);

// ==== bench/dma_tb.sv ====
`timescale 1ns/1ps

module dma_tb;

  localparam int TOTAL_BEATS = 8 + 2 * 16 + 2 * 12 + 2 * 1;  // beats moved by all tests
  localparam int STALL_BOUND = 40;  // cycles allowed per beat with the overhead included

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        dir;
  logic [31:0] src_addr;
  logic [31:0] dst_addr;
  logic [31:0] len;
  logic        stall_en;
  logic        done;
  logic        idle;
  logic        rd_req_valid;
  logic        rd_req_ready;
  logic        rd_data_valid;
  logic        rd_data_ready;
  logic        wr_req_valid;
  logic        wr_req_ready;
  logic        wr_data_valid;
  logic        wr_data_ready;
  logic [31:0] rd_req_addr;
  logic [31:0] rd_req_len;
  logic [31:0] wr_req_addr;
  logic [31:0] wr_req_len;
  logic [31:0] rd_data;
  logic [31:0] wr_data;
  logic [2:0]  rd_req_size;
  logic [2:0]  wr_req_size;
  logic [1:0]  rd_req_burst;
  logic [1:0]  wr_req_burst;
  logic [31:0] ref_words [$];
  string       test_name = "";

  tb_clock i_clock (.clk(clk), .rst_n(rst_n));

  dma_top i_dut (.*);

  tb_ddr_model i_ddr (.*);

  initial begin
    start    = 1'b0;
    dir      = 1'b0;
    src_addr = '0;
    dst_addr = '0;
    len      = 32'd1;
    stall_en = 1'b0;
  end

  initial begin
    #(TOTAL_BEATS * STALL_BOUND * 8);
    $display("timeout, a transfer never finished");
    $display("STATUS: FAIL");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // pulses start and waits for done on the falling edge
  task automatic run_transfer(input logic d, input logic [31:0] s, input logic [31:0] t,
                              input logic [31:0] n);
    int reqs_before;
    reqs_before = i_ddr.req_count;
    @(posedge clk);
    start    <= 1'b1;
    dir      <= d;
    src_addr <= s;
    dst_addr <= t;
    len      <= n;
    @(posedge clk);
    start <= 1'b0;
    do @(negedge clk); while (!done);
    check_value("idle with done", 1, idle);
    check_value("one request per transfer", reqs_before + 1, i_ddr.req_count);
  endtask

  task automatic fill_ddr(input logic [31:0] base, input int n);
    logic [31:0] w;
    ref_words.delete();
    for (int i = 0; i < n; i++) begin
      w = i_ddr.rand_word();
      i_ddr.mem[(base + i) % 4096] = w;
      ref_words.push_back(w);
    end
  endtask

  task automatic check_ddr(input string name, input logic [31:0] base);
    foreach (ref_words[i]) check_value(name, ref_words[i], i_ddr.mem[(base + i) % 4096]);
  endtask

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk);
    check_value("reset idle", 1, idle);
    check_value("reset done", 0, done);
    check_value("reset valids", 0, {rd_req_valid, rd_data_ready, wr_req_valid, wr_data_valid});
  endtask

  task automatic test_read_path();
    test_name = "read_path";
    fill_ddr(32'd40, 8);
    run_transfer(1'b0, 32'd40, 32'd300, 32'd8);
    check_value("read req addr", 32'd40, i_ddr.log_addr);
    check_value("read req len", 32'd7, i_ddr.log_len);
    check_value("read req size", 3'b010, i_ddr.log_size);
    check_value("read req burst", 2'b01, i_ddr.log_burst);
    foreach (ref_words[i]) check_value("read dmem", ref_words[i], i_dut.i_ram.ram[300 + i]);
  endtask

  task automatic test_round_trip();
    test_name = "round_trip";
    stall_en = 1'b1;
    fill_ddr(32'd500, 16);
    run_transfer(1'b0, 32'd500, 32'd100, 32'd16);
    run_transfer(1'b1, 32'd100, 32'd2000, 32'd16);
    check_value("write req addr", 32'd2000, i_ddr.log_addr);
    check_value("round trip len", 32'd15, i_ddr.log_len);
    check_value("write req size", 3'b010, i_ddr.log_size);
    check_value("write req burst", 2'b01, i_ddr.log_burst);
    check_ddr("round trip data", 32'd2000);
  endtask

  task automatic test_backpressure();
    int beats_before;
    test_name = "backpressure";
    fill_ddr(32'd700, 12);
    run_transfer(1'b0, 32'd700, 32'd400, 32'd12);
    beats_before = i_ddr.wr_beats;
    run_transfer(1'b1, 32'd400, 32'd3000, 32'd12);
    check_value("write beat count", 32'd12, i_ddr.wr_beats - beats_before);
    check_ddr("write data order", 32'd3000);
  endtask

  task automatic test_done_single();
    test_name = "done_single";
    repeat (5) @(negedge clk);
    check_value("done held", 1, done);
    fill_ddr(32'd900, 1);
    @(posedge clk);
    start    <= 1'b1;
    dir      <= 1'b0;
    src_addr <= 32'd900;
    dst_addr <= 32'd800;
    len      <= 32'd1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("done cleared", 0, done);
    do @(negedge clk); while (!done);
    run_transfer(1'b1, 32'd800, 32'd3500, 32'd1);
    check_value("single len", 32'd0, i_ddr.log_len);
    check_ddr("single word", 32'd3500);
  endtask

  initial begin
    @(posedge rst_n);
    test_reset();
    test_read_path();
    test_round_trip();
    test_backpressure();
    test_done_single();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
source/dma_pkg.sv
source/dma_if.sv
source/dma_cmd_latch.sv
source/dma_xfer_counter.sv
source/dmem_ram.sv
source/dma_ctrl.sv
source/dma_top.sv
bench/tb_clock.sv
bench/tb_ddr_model.sv
bench/dma_sva.sv
bench/dma_tb.sv
